// ==== Makefile ====
SIM := obj_dir/Vtb_ldst_check
SOURCES := $(wildcard design/*.sv verif/*.sv)

.PHONY: run clean

run: $(SIM)
	-$(SIM) +verilator+error+limit+1000 > sim.log 2>&1
	cat sim.log
	grep -q '^TEST PASSED$$' sim.log

$(SIM): tb.f $(SOURCES)
	verilator --binary --timing --assert --top-module tb_ldst_check -f tb.f

clean:
	rm -rf obj_dir sim.log

// ==== design/ldst_check_top.sv ====
module ldst_check_top (
	input logic iCLOCK,
	input logic inRESET,
	input logic reset_sync,
	input logic event_hold,
	input logic issue_valid,
	input logic issue_kernel,
	input logic issue_paging,
	input logic issue_write,
	input logic [ldst_pkg::VPAGE_W-1:0] issue_vpage,
	input logic cfg_write,
	input logic [ldst_pkg::VPAGE_W-1:0] cfg_vpage,
	input logic [ldst_pkg::MMU_FLAG_W-1:0] cfg_flags,
	output logic issue_stall,
	output logic result_done,
	output ldst_pkg::ldst_result_t result
);

	logic push;
	logic pop;
	logic empty;
	logic full;
	logic almost_full;
	ldst_pkg::ldst_req_t push_req;
	ldst_pkg::ldst_req_t head;

	// Producer, captures context and page attributes
	ldst_issue i_issue (
		.iCLOCK(iCLOCK),
		.inRESET(inRESET),
		.reset_sync(reset_sync),
		.issue_valid(issue_valid),
		.issue_kernel(issue_kernel),
		.issue_paging(issue_paging),
		.issue_write(issue_write),
		.issue_vpage(issue_vpage),
		.cfg_write(cfg_write),
		.cfg_vpage(cfg_vpage),
		.cfg_flags(cfg_flags),
		.queue_full(full),
		.queue_almost_full(almost_full),
		.issue_stall(issue_stall),
		.push(push),
		.push_req(push_req)
	);

	ldst_queue i_queue (
		.iCLOCK(iCLOCK),
		.inRESET(inRESET),
		.flush(reset_sync),
		.push(push),
		.push_req(push_req),
		.pop(pop),
		.head(head),
		.empty(empty),
		.full(full),
		.almost_full(almost_full)
	);

	// Consumer, stalled by the event hold
	ldst_priv_check i_check (
		.iCLOCK(iCLOCK),
		.inRESET(inRESET),
		.reset_sync(reset_sync),
		.event_hold(event_hold),
		.empty(empty),
		.head(head),
		.pop(pop),
		.result_done(result_done),
		.result(result)
	);

endmodule

// ==== design/ldst_issue.sv ====
module ldst_issue (
	input logic iCLOCK,
	input logic inRESET,
	input logic reset_sync,
	input logic issue_valid,
	input logic issue_kernel,
	input logic issue_paging,
	input logic issue_write,
	input logic [ldst_pkg::VPAGE_W-1:0] issue_vpage,
	input logic cfg_write,
	input logic [ldst_pkg::VPAGE_W-1:0] cfg_vpage,
	input logic [ldst_pkg::MMU_FLAG_W-1:0] cfg_flags,
	input logic queue_full,
	input logic queue_almost_full,
	output logic issue_stall,
	output logic push,
	output ldst_pkg::ldst_req_t push_req
);

	logic [ldst_pkg::MMU_FLAG_W-1:0] attr_table [ldst_pkg::PAGE_COUNT];
	logic issue_accept;

	// A pending push into an almost full queue would fill it
	assign issue_stall = queue_full || (push && queue_almost_full);
	assign issue_accept = issue_valid && !issue_stall;

	// Page attribute table
	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			for (int i = 0; i < ldst_pkg::PAGE_COUNT; i++) begin
				attr_table[i] <= '0;
			end
		end else if (cfg_write) begin
			attr_table[cfg_vpage] <= cfg_flags;
		end
	end

	// Push strobe, one cycle after the accepted issue
	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			push <= 1'b0;
		end else if (reset_sync) begin
			push <= 1'b0;
		end else begin
			push <= issue_accept;
		end
	end

	// Context and attribute word captured together
	// Lookup sees the table before a same-cycle cfg write
	always_ff @(posedge iCLOCK) begin
		if (issue_accept) begin
			push_req.kernel <= issue_kernel;
			push_req.paging <= issue_paging;
			push_req.write <= issue_write;
			push_req.vpage <= issue_vpage;
			push_req.mmu_flags <= attr_table[issue_vpage];
		end
	end

endmodule

// ==== design/ldst_pkg.sv ====
package ldst_pkg;

	// Virtual page number and page attribute table size
	localparam int VPAGE_W = 4;
	localparam int PAGE_COUNT = 16;

	// Page attribute word, privilege field in the top two bits
	localparam int MMU_FLAG_W = 6;
	localparam int MMU_PRIV_HI = 5;
	localparam int MMU_PRIV_LO = 4;

	// Exception numbering
	localparam int EXC_NUM_W = 7;
	localparam logic [EXC_NUM_W-1:0] EXC_PRIVILEGE_ERROR = 7'h14;

	// Request queue sizing
	localparam int QUEUE_DEPTH = 4;
	localparam int QUEUE_PTR_W = 2;
	localparam int QUEUE_CNT_W = 3;
	localparam logic [QUEUE_CNT_W-1:0] QUEUE_CNT_FULL = 3'd4;
	localparam logic [QUEUE_CNT_W-1:0] QUEUE_CNT_ALMOST = 3'd3;

	// One queued load or store with its looked-up attributes
	typedef struct packed {
		logic kernel;
		logic paging;
		logic write;
		logic [VPAGE_W-1:0] vpage;
		logic [MMU_FLAG_W-1:0] mmu_flags;
	} ldst_req_t;

	typedef struct packed {
		logic except_valid;
		logic [EXC_NUM_W-1:0] except_num;
	} ldst_result_t;

	// Code 1 also forbids kernel writes
	typedef enum logic [1:0] {
		PRIV_KERNEL_ONLY = 2'd0,
		PRIV_KERNEL_RW_USER_RO = 2'd1,
		PRIV_USER_RO = 2'd2,
		PRIV_USER_RW = 2'd3
	} ldst_priv_t;

endpackage

// ==== design/ldst_priv_check.sv ====
module ldst_priv_check (
	input logic iCLOCK,
	input logic inRESET,
	input logic reset_sync,
	input logic event_hold,
	input logic empty,
	input ldst_pkg::ldst_req_t head,
	output logic pop,
	output logic result_done,
	output ldst_pkg::ldst_result_t result
);

	ldst_pkg::ldst_result_t check;

	// Privilege rule on the MMU flag field
	function automatic ldst_pkg::ldst_result_t priv_check(input ldst_pkg::ldst_req_t req);
		ldst_pkg::ldst_priv_t priv;
		logic violation;
		priv = ldst_pkg::ldst_priv_t'(req.mmu_flags[ldst_pkg::MMU_PRIV_HI:ldst_pkg::MMU_PRIV_LO]);
		violation = 1'b0;
		if (req.paging) begin
			if (req.kernel) begin
				// Kernel mode trips only on a write to code 1
				violation = (priv == ldst_pkg::PRIV_KERNEL_RW_USER_RO) && req.write;
			end else begin
				case (priv)
					ldst_pkg::PRIV_KERNEL_ONLY: violation = 1'b1;
					ldst_pkg::PRIV_KERNEL_RW_USER_RO: violation = req.write;
					ldst_pkg::PRIV_USER_RO: violation = req.write;
					ldst_pkg::PRIV_USER_RW: violation = 1'b0;
					default: violation = 1'b0;
				endcase
			end
		end
		priv_check.except_valid = violation;
		priv_check.except_num = violation ? ldst_pkg::EXC_PRIVILEGE_ERROR : '0;
	endfunction

	assign pop = !empty && !event_hold && !reset_sync;
	assign check = priv_check(head);

	// Done pulse follows the pop by one cycle
	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			result_done <= 1'b0;
		end else if (reset_sync) begin
			result_done <= 1'b0;
		end else begin
			result_done <= pop;
		end
	end

	// Result held until the next pop
	always_ff @(posedge iCLOCK) begin
		if (pop) begin
			result <= check;
		end
	end

endmodule

// ==== design/ldst_queue.sv ====
module ldst_queue (
	input logic iCLOCK,
	input logic inRESET,
	input logic flush,
	input logic push,
	input ldst_pkg::ldst_req_t push_req,
	input logic pop,
	output ldst_pkg::ldst_req_t head,
	output logic empty,
	output logic full,
	output logic almost_full
);

	ldst_pkg::ldst_req_t mem [ldst_pkg::QUEUE_DEPTH];
	logic [ldst_pkg::QUEUE_PTR_W-1:0] wr_ptr;
	logic [ldst_pkg::QUEUE_PTR_W-1:0] rd_ptr;
	logic [ldst_pkg::QUEUE_CNT_W-1:0] count;

	// Levels straight from the occupancy count
	assign empty = (count == '0);
	assign full = (count == ldst_pkg::QUEUE_CNT_FULL);
	assign almost_full = (count == ldst_pkg::QUEUE_CNT_ALMOST);
	assign head = mem[rd_ptr];

	// Storage, written at the tail
	always_ff @(posedge iCLOCK) begin
		if (push) begin
			mem[wr_ptr] <= push_req;
		end
	end

	// Pointers wrap naturally, depth is a power of two
	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
		end else if (flush) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
		end else begin
			if (push) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (pop) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
		end
	end

	// Occupancy, push and pop together leave it unchanged
	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			count <= '0;
		end else if (flush) begin
			count <= '0;
		end else begin
			case ({push, pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

endmodule

// ==== tb.f ====
design/ldst_pkg.sv
design/ldst_issue.sv
design/ldst_queue.sv
design/ldst_priv_check.sv
design/ldst_check_top.sv
verif/ldst_check_assertions.sv
verif/tb_ldst_check.sv

// ==== verif/ldst_check_assertions.sv ====
module ldst_check_assertions (
	input logic iCLOCK,
	input logic inRESET,
	input logic reset_sync,
	input logic event_hold,
	input logic issue_valid,
	input logic issue_kernel,
	input logic issue_paging,
	input logic issue_write,
	input logic [ldst_pkg::VPAGE_W-1:0] issue_vpage,
	input logic cfg_write,
	input logic [ldst_pkg::VPAGE_W-1:0] cfg_vpage,
	input logic [ldst_pkg::MMU_FLAG_W-1:0] cfg_flags,
	input logic issue_stall,
	input logic result_done,
	input ldst_pkg::ldst_result_t result,
	input logic push,
	input logic full,
	input logic empty
);

	int error_count = 0;
	logic [ldst_pkg::MMU_FLAG_W-1:0] page_flags [ldst_pkg::PAGE_COUNT];
	ldst_pkg::ldst_result_t expected [8];
	logic [2:0] sb_wr;
	logic [2:0] sb_rd;
	logic [3:0] sb_count;
	logic [2:0] lat;
	logic accept;
	logic stall_expect;
	ldst_pkg::ldst_result_t next_expect;

	// Allowed accesses per privilege code
	function automatic ldst_pkg::ldst_result_t expect_result(input logic kernel,
			input logic paging, input logic write, input logic [ldst_pkg::MMU_FLAG_W-1:0] flags);
		logic [1:0] code;
		logic allowed;
		code = flags[ldst_pkg::MMU_PRIV_HI:ldst_pkg::MMU_PRIV_LO];
		if (!paging) begin
			allowed = 1'b1;
		end else if (kernel) begin
			allowed = !(write && code == 2'd1);
		end else if (write) begin
			allowed = (code == 2'd3);
		end else begin
			allowed = (code != 2'd0);
		end
		expect_result.except_valid = !allowed;
		expect_result.except_num = allowed ? '0 : ldst_pkg::EXC_PRIVILEGE_ERROR;
	endfunction

	assign accept = issue_valid && !issue_stall;
	assign next_expect = expect_result(issue_kernel, issue_paging, issue_write,
		page_flags[issue_vpage]);

	// Queue capacity used up by outstanding requests
	assign stall_expect = (sb_count >= ldst_pkg::QUEUE_DEPTH);

	// Shadow copy of the attribute table
	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			for (int i = 0; i < ldst_pkg::PAGE_COUNT; i++) begin
				page_flags[i] <= '0;
			end
		end else if (cfg_write) begin
			page_flags[cfg_vpage] <= cfg_flags;
		end
	end

	always_ff @(posedge iCLOCK) begin
		if (accept) begin
			expected[sb_wr] <= next_expect;
		end
	end

	// Scoreboard pointers flushed along with the queue
	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			sb_wr <= '0;
			sb_rd <= '0;
			sb_count <= '0;
		end else if (reset_sync) begin
			sb_wr <= '0;
			sb_rd <= '0;
			sb_count <= '0;
		end else begin
			sb_wr <= sb_wr + {2'b0, accept};
			sb_rd <= sb_rd + {2'b0, result_done};
			sb_count <= sb_count + {3'b0, accept} - {3'b0, result_done};
		end
	end

	// Issue into an idle path tracked up to its done cycle
	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			lat <= '0;
		end else begin
			lat[0] <= accept && empty && !push && !reset_sync;
			lat[1] <= lat[0] && !reset_sync;
			lat[2] <= lat[1] && !reset_sync && !event_hold;
		end
	end

	result_value: assert property (@(posedge iCLOCK) disable iff (!inRESET)
		(result_done && sb_count != 0) |-> result == expected[sb_rd])
		else begin
			error_count++;
			$error("CHECK FAILED t=%0t result expected %h actual %h", $time,
				$sampled(expected[sb_rd]), $sampled(result));
		end

	result_outstanding: assert property (@(posedge iCLOCK) disable iff (!inRESET)
		result_done |-> sb_count != 0)
		else begin
			error_count++;
			$error("result_done pulsed at %0t with no request outstanding", $time);
		end

	hold_blocks_done: assert property (@(posedge iCLOCK) disable iff (!inRESET)
		event_hold |=> !result_done)
		else begin
			error_count++;
			$error("CHECK FAILED t=%0t result_done expected 0 actual 1", $time);
		end

	push_not_full: assert property (@(posedge iCLOCK) disable iff (!inRESET)
		push |-> !full)
		else begin
			error_count++;
			$error("Request pushed into a full queue at %0t", $time);
		end

	// No result in flight under a steady hold
	stall_on_full: assert property (@(posedge iCLOCK) disable iff (!inRESET)
		(event_hold && $past(event_hold)) |-> issue_stall == stall_expect)
		else begin
			error_count++;
			$error("CHECK FAILED t=%0t issue_stall expected %0d actual %0d", $time,
				$sampled(stall_expect), $sampled(issue_stall));
		end

	idle_latency: assert property (@(posedge iCLOCK) disable iff (!inRESET)
		lat[2] |-> result_done)
		else begin
			error_count++;
			$error("CHECK FAILED t=%0t result_done expected 1 actual 0", $time);
		end

endmodule

bind ldst_check_top ldst_check_assertions i_assertions (.*);

// ==== verif/tb_ldst_check.sv ====
module tb_ldst_check;

	localparam int RAND_STEPS = 60;
	localparam int ISSUE_TOTAL = 16 + 8 + 4 + 5 + 4 + RAND_STEPS;

	logic iCLOCK;
	logic inRESET;
	logic reset_sync;
	logic event_hold;
	logic issue_valid;
	logic issue_kernel;
	logic issue_paging;
	logic issue_write;
	logic [ldst_pkg::VPAGE_W-1:0] issue_vpage;
	logic cfg_write;
	logic [ldst_pkg::VPAGE_W-1:0] cfg_vpage;
	logic [ldst_pkg::MMU_FLAG_W-1:0] cfg_flags;
	logic issue_stall;
	logic result_done;
	ldst_pkg::ldst_result_t result;

	logic [15:0] lfsr = 16'd54420;
	int issued_cnt = 0;
	int done_cnt = 0;
	int tests_run = 0;

	ldst_check_top i_dut (.*);

	always #5 iCLOCK = ~iCLOCK;

	// Done pulse counted at the rising edge that ends it
	always @(posedge iCLOCK) begin
		if (result_done) begin
			done_cnt++;
		end
	end

	initial begin
		repeat (ISSUE_TOTAL * 20 + 500) @(posedge iCLOCK);
		$display("Run timed out before all results arrived");
		$display("TEST FAILED");
		$finish;
	end

	// Galois LFSR stepped once per bit taken
	function automatic logic [15:0] take_bits(input int count);
		logic [15:0] bits;
		bits = '0;
		for (int i = 0; i < count; i++) begin
			bits = {bits[14:0], lfsr[0]};
			lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hB400) : (lfsr >> 1);
		end
		return bits;
	endfunction

	task automatic issue_req(input logic kernel, input logic paging, input logic write,
			input logic [ldst_pkg::VPAGE_W-1:0] vpage);
		while (issue_stall) begin
			@(negedge iCLOCK);
		end
		issue_valid = 1'b1;
		issue_kernel = kernel;
		issue_paging = paging;
		issue_write = write;
		issue_vpage = vpage;
		@(negedge iCLOCK);
		issue_valid = 1'b0;
		cfg_write = 1'b0;
		issued_cnt++;
	endtask

	task automatic cfg_page(input logic [ldst_pkg::VPAGE_W-1:0] vpage,
			input logic [ldst_pkg::MMU_FLAG_W-1:0] flags);
		cfg_write = 1'b1;
		cfg_vpage = vpage;
		cfg_flags = flags;
		@(negedge iCLOCK);
		cfg_write = 1'b0;
	endtask

	task automatic wait_drain();
		while (done_cnt != issued_cnt) begin
			@(negedge iCLOCK);
		end
	endtask

	task automatic report_test(input string name);
		tests_run++;
		$display("%-12s finished, assertion failures so far %0d", name,
			i_dut.i_assertions.error_count);
	endtask

	task automatic random_mix();
		logic [15:0] act;
		logic [15:0] page;
		logic [15:0] flags;
		logic [15:0] ctx;
		for (int step = 0; step < RAND_STEPS; step++) begin
			act = take_bits(3);
			page = take_bits(4);
			if (act[2:0] < 3'd2) begin
				flags = take_bits(6);
				cfg_page(page[3:0], flags[5:0]);
			end else if (act[2:0] < 3'd6) begin
				// Code 5 also rewrites the page in the issue cycle
				if (act[2:0] == 3'd5) begin
					flags = take_bits(6);
					cfg_write = 1'b1;
					cfg_vpage = page[3:0];
					cfg_flags = flags[5:0];
				end
				ctx = take_bits(3);
				issue_req(ctx[2], ctx[1], ctx[0], page[3:0]);
			end else begin
				event_hold = 1'b1;
				repeat (1 + int'(page[1:0])) @(negedge iCLOCK);
				event_hold = 1'b0;
			end
		end
		wait_drain();
	endtask

	initial begin
		int fails;
		iCLOCK = 1'b0;
		inRESET = 1'b0;
		reset_sync = 1'b0;
		event_hold = 1'b0;
		issue_valid = 1'b0;
		issue_kernel = 1'b0;
		issue_paging = 1'b0;
		issue_write = 1'b0;
		issue_vpage = '0;
		cfg_write = 1'b0;
		cfg_vpage = '0;
		cfg_flags = '0;
		repeat (4) @(posedge iCLOCK);
		@(negedge iCLOCK);
		inRESET = 1'b1;
		@(negedge iCLOCK);

		// Pages 1 to 4 carry privilege codes 0 to 3
		for (int code = 0; code < 4; code++) begin
			cfg_page(4'(code + 1), {2'(code), 4'b1010});
		end
		for (int n = 0; n < 16; n++) begin
			issue_req(n[3], 1'b1, n[2], 4'(n % 4 + 1));
		end
		wait_drain();
		report_test("priv_matrix");

		for (int n = 0; n < 8; n++) begin
			issue_req(n[0], 1'b0, 1'b1, 4'(n % 4 + 1));
		end
		wait_drain();
		report_test("paging_off");

		// Queue fills under hold until the stall rises
		event_hold = 1'b1;
		for (int n = 0; n < 4; n++) begin
			issue_req(1'b0, 1'b1, n[0], 4'(n + 1));
		end
		while (!issue_stall) begin
			@(negedge iCLOCK);
		end
		repeat (3) @(negedge iCLOCK);
		event_hold = 1'b0;
		wait_drain();
		report_test("hold_fill");

		event_hold = 1'b1;
		for (int n = 0; n < 3; n++) begin
			issue_req(1'b1, 1'b1, 1'b1, 4'(n + 1));
		end
		reset_sync = 1'b1;
		@(negedge iCLOCK);
		reset_sync = 1'b0;
		issued_cnt = done_cnt;
		event_hold = 1'b0;
		issue_req(1'b0, 1'b1, 1'b0, 4'd1);
		issue_req(1'b0, 1'b1, 1'b1, 4'd3);
		wait_drain();
		report_test("sync_flush");

		for (int n = 0; n < 4; n++) begin
			issue_req(1'b0, 1'b1, n[0], 4'd4);
			wait_drain();
		end
		report_test("latency");

		random_mix();
		report_test("random_mix");

		fails = i_dut.i_assertions.error_count;
		$display("%0d tests run, %0d assertion failures", tests_run, fails);
		if (fails == 0) begin
			$display("TEST PASSED");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule
